//--- include/hex_dump_consts.svh
`ifndef HEX_DUMP_CONSTS_SVH
`define HEX_DUMP_CONSTS_SVH

`define HD_DEPTH 256 // capture buffer words
`define HD_AW 8
`define HD_WW 16 // sixteen samples per word

// apb byte offsets
`define HD_REG_CTRL 8'h00 // bit 0 enable
`define HD_REG_SDIV 8'h04
`define HD_REG_POST 8'h08
`define HD_REG_BAUD 8'h0C
`define HD_REG_STAT 8'h10 // read only

`endif

//--- hdl/capture_pkg.sv
`include "hex_dump_consts.svh"

package capture_pkg;

    typedef enum logic [2:0] {
        CAPTURE,
        POST,
        FETCH,
        SEND_LO,
        SEND_HI,
        IDLE
    } dump_state_e;

    typedef enum logic [7:0] {
        REG_CTRL = `HD_REG_CTRL,
        REG_SDIV = `HD_REG_SDIV,
        REG_POST = `HD_REG_POST,
        REG_BAUD = `HD_REG_BAUD,
        REG_STAT = `HD_REG_STAT
    } reg_off_e;

    typedef struct packed {
        logic        enable;
        logic [15:0] sample_div; // one sample every sample_div+1 clocks
        logic [7:0]  post_words; // words kept after the trigger
        logic [15:0] baud_div;   // clocks per bit minus one
    } cfg_t;

    typedef struct packed {
        logic       dumping;
        logic       triggered;
        logic [7:0] dump_count; // wraps
    } stat_t;

endpackage

//--- hdl/dump_regs.sv
`timescale 1ns/1ns

module dump_regs import capture_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    input  stat_t       stat,
    output logic [31:0] prdata,
    output logic        pready,
    output cfg_t        cfg
);

    logic wr_stb;

    assign wr_stb = psel && penable && pwrite; // access phase
    assign pready = 1'b1; // no wait states

    always_ff @(posedge clk) begin
        if (!rst) begin
            cfg <= '0;
        end else if (wr_stb) begin
            case (paddr)
                REG_CTRL: cfg.enable <= pwdata[0];
                REG_SDIV: cfg.sample_div <= pwdata[15:0];
                REG_POST: cfg.post_words <= pwdata[7:0];
                REG_BAUD: cfg.baud_div <= pwdata[15:0];
                default: ; // status and holes are read only
            endcase
        end
    end

    // status layout: bit 0 dumping, bit 1 triggered, bits 15:8 dump count
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[0] = cfg.enable;
            end
            REG_SDIV: begin
                prdata[15:0] = cfg.sample_div;
            end
            REG_POST: begin
                prdata[7:0] = cfg.post_words;
            end
            REG_BAUD: begin
                prdata[15:0] = cfg.baud_div;
            end
            REG_STAT: begin
                prdata[0] = stat.dumping;
                prdata[1] = stat.triggered;
                prdata[15:8] = stat.dump_count;
            end
            default: begin
                prdata = '0; // unmapped
            end
        endcase
    end

endmodule

//--- hdl/bit_sampler.sv
`timescale 1ns/1ns
`include "hex_dump_consts.svh"

module bit_sampler import capture_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  cfg_t              cfg,
    input  logic              sig,
    output logic [`HD_WW-1:0] word,
    output logic              word_valid
);

    logic [15:0]       div_cnt;
    logic [3:0]        bit_cnt;
    logic [`HD_WW-1:0] shreg;
    logic              tick;

    assign tick = cfg.enable && (div_cnt >= cfg.sample_div);
    assign word = shreg; // stable while word_valid is high

    always_ff @(posedge clk) begin
        if (!rst || !cfg.enable) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (tick) begin
                div_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
                word_valid <= (bit_cnt == 4'd15); // sixteenth bit going in
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick) begin
            shreg <= {shreg[`HD_WW-2:0], sig}; // oldest ends in bit 15
        end
    end

endmodule

//--- hdl/capture_ram.sv
`timescale 1ns/1ns
`include "hex_dump_consts.svh"

module capture_ram (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [`HD_AW-1:0] wr_addr,
    input  logic [`HD_WW-1:0] wr_data,
    input  logic [`HD_AW-1:0] rd_addr,
    output logic [`HD_WW-1:0] rd_data
);

    logic [`HD_WW-1:0] mem [`HD_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // one cycle latency
    end

endmodule

//--- hdl/dump_sequencer.sv
`timescale 1ns/1ns
`include "hex_dump_consts.svh"

module dump_sequencer import capture_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  cfg_t              cfg,
    input  logic [`HD_WW-1:0] word,
    input  logic              word_valid,
    input  logic              trig,
    input  logic [`HD_WW-1:0] rd_data,
    input  logic              tx_busy,
    output logic              wr_en,
    output logic [`HD_AW-1:0] wr_addr,
    output logic [`HD_WW-1:0] wr_data,
    output logic [`HD_AW-1:0] rd_addr,
    output logic [7:0]        tx_data,
    output logic              tx_start,
    output stat_t             stat
);

    dump_state_e       state;
    logic [2:0]        trig_sync;
    logic              trig_rise;
    logic [`HD_AW-1:0] wr_ptr;
    logic [`HD_AW-1:0] wr_ptr_next;
    logic [`HD_AW-1:0] rd_ptr;
    logic [7:0]        post_cnt;
    logic [`HD_AW:0]   word_cnt;
    logic [7:0]        dump_count;
    logic              dumping;
    logic              tx_free;

    assign trig_rise = trig_sync[1] & ~trig_sync[2];
    assign tx_free = !tx_busy && !tx_start; // busy only shows a cycle after start
    assign dumping = (state == FETCH) || (state == SEND_LO) || (state == SEND_HI);

    assign wr_en = word_valid && ((state == CAPTURE) || (state == POST));
    assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;
    assign wr_addr = wr_ptr;
    assign wr_data = word;
    assign rd_addr = rd_ptr;

    assign stat.dumping = dumping;
    assign stat.triggered = dumping || (state == POST);
    assign stat.dump_count = dump_count;

    always_ff @(posedge clk) begin
        if (!rst) begin
            trig_sync <= '0;
        end else begin
            trig_sync <= {trig_sync[1:0], trig};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            post_cnt <= '0;
            word_cnt <= '0;
            dump_count <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            wr_ptr <= wr_ptr_next;
            if (!dumping) begin
                rd_ptr <= wr_ptr_next; // oldest word once capture freezes
                word_cnt <= '0;
            end
            case (state)
                IDLE: begin
                    if (cfg.enable) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (!cfg.enable) begin
                        state <= IDLE;
                    end else if (trig_rise) begin
                        post_cnt <= cfg.post_words;
                        state <= (cfg.post_words == 8'd0) ? FETCH : POST;
                    end
                end
                POST: begin
                    if (!cfg.enable) begin
                        state <= IDLE;
                    end else if (word_valid) begin
                        post_cnt <= post_cnt - 1'b1;
                        if (post_cnt == 8'd1) begin
                            state <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (word_cnt != `HD_DEPTH) begin
                        state <= SEND_LO; // read data lands next cycle
                    end else if (tx_free) begin
                        dump_count <= dump_count + 1'b1; // last stop bit is out
                        state <= cfg.enable ? CAPTURE : IDLE;
                    end
                end
                SEND_LO: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        state <= SEND_HI;
                    end
                end
                SEND_HI: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        rd_ptr <= rd_ptr + 1'b1;
                        word_cnt <= word_cnt + 1'b1;
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_free && (state == SEND_LO)) begin
            tx_data <= rd_data[7:0];
        end else if (tx_free && (state == SEND_HI)) begin
            tx_data <= rd_data[15:8];
        end
    end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import capture_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cfg_t       cfg,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       txd
);

    logic [9:0]  frame;
    logic [15:0] baud_cnt;
    logic [3:0]  bit_cnt;

    assign txd = frame[0] | ~tx_busy; // idle high

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_busy <= 1'b0;
            baud_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                baud_cnt <= cfg.baud_div;
                bit_cnt <= '0;
            end
        end else if (baud_cnt != 16'd0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_cnt == 4'd9) begin
            tx_busy <= 1'b0; // stop bit elapsed
        end else begin
            baud_cnt <= cfg.baud_div;
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // start, 8 data lsb first, stop
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && (baud_cnt == 16'd0)) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

//--- hdl/hex_dump_top.sv
`timescale 1ns/1ns
`include "hex_dump_consts.svh"

module hex_dump_top import capture_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        sig,
    input  logic        trig,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        txd
);

    cfg_t              cfg;
    stat_t             stat;
    logic [`HD_WW-1:0] word;
    logic              word_valid;
    logic              wr_en;
    logic [`HD_AW-1:0] wr_addr;
    logic [`HD_WW-1:0] wr_data;
    logic [`HD_AW-1:0] rd_addr;
    logic [`HD_WW-1:0] rd_data;
    logic [7:0]        tx_data;
    logic              tx_start;
    logic              tx_busy;

    dump_regs u_regs (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .stat(stat),
        .prdata(prdata), .pready(pready), .cfg(cfg)
    );

    bit_sampler u_sampler (
        .clk(clk), .rst(rst), .cfg(cfg), .sig(sig),
        .word(word), .word_valid(word_valid)
    );

    capture_ram u_ram (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    dump_sequencer u_seq (
        .clk(clk), .rst(rst), .cfg(cfg), .word(word), .word_valid(word_valid),
        .trig(trig), .rd_data(rd_data), .tx_busy(tx_busy),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr),
        .tx_data(tx_data), .tx_start(tx_start), .stat(stat)
    );

    uart_tx u_tx (
        .clk(clk), .rst(rst), .cfg(cfg), .tx_data(tx_data), .tx_start(tx_start),
        .tx_busy(tx_busy), .txd(txd)
    );

endmodule

//--- test/hex_dump_assertions.sv
`timescale 1ns/1ns

module hex_dump_assertions (
    input logic clk,
    input logic rst,
    input logic tx_start,
    input logic tx_busy,
    input logic txd,
    input logic dumping
);

    // start pulse only toward an idle transmitter
    start_idle: assert property (@(posedge clk) disable iff (!rst) tx_start |-> !tx_busy)
        else $error("tx_start issued while the transmitter is busy");

    busy_follows: assert property (@(posedge clk) disable iff (!rst) tx_start |=> tx_busy)
        else $error("tx_busy did not rise on the cycle after tx_start");

    // line idle outside a dump
    line_idle: assert property (@(posedge clk) disable iff (!rst) !dumping |-> txd)
        else $error("serial line low while no dump is running");

endmodule

//--- test/hex_dump_tb.sv
`timescale 1ns/1ns
`include "hex_dump_consts.svh"

module hex_dump_tb;

    localparam int SDIV = 1;
    localparam int POST_WORDS = 20;
    localparam int BAUD = 3;
    localparam int TRIG_WORDS = 300; // words captured before each trigger
    localparam int QUIET_CYCLES = 16 * (SDIV + 1) * (POST_WORDS + 16);
    localparam int TIMEOUT_CYCLES = 3 * (2 * (TRIG_WORDS + POST_WORDS) * 16 * (SDIV + 1)
        + 2 * 5120 * (BAUD + 1) + QUIET_CYCLES) / 2;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic        sig;
    logic        trig;
    logic [31:0] prdata;
    logic        pready;
    logic        txd;

    integer     seed;
    integer     rnd;
    logic       en_model;
    int         cycle_count;
    logic       sample_log[$]; // index is the sample number since enable
    logic [7:0] rx_bytes[$];

    hex_dump_top uut (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .sig(sig), .trig(trig),
        .prdata(prdata), .pready(pready), .txd(txd)
    );

    bind hex_dump_top hex_dump_assertions u_chk (
        .clk(clk), .rst(rst), .tx_start(tx_start), .tx_busy(tx_busy), .txd(txd),
        .dumping(stat.dumping)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one logged sample every SDIV+1 clocks after the enable write
    initial begin
        int clk_since_en;
        clk_since_en = 0;
        seed = 88;
        sig = 1'b0;
        forever begin
            @(posedge clk);
            if (en_model) begin
                clk_since_en = clk_since_en + 1;
                if (clk_since_en % (SDIV + 1) == 0) begin
                    sample_log.push_back(sig); // value seen at this edge
                end
            end else begin
                clk_since_en = 0;
            end
            rnd = $random(seed);
            sig <= rnd[0];
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0h expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk); // write lands on this edge
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata; // middle of the access phase
        check_equal("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_frame(output logic [7:0] data);
        int i;
        @(negedge clk);
        while (txd !== 1'b0) begin
            @(negedge clk);
        end
        repeat ((BAUD + 1) / 2) @(negedge clk); // mid start bit
        check_equal("txd start bit", 32'(txd), 32'd0);
        for (i = 0; i < 8; i++) begin
            repeat (BAUD + 1) @(negedge clk);
            data[i] = txd;
        end
        repeat (BAUD + 1) @(negedge clk);
        check_equal("txd stop bit", 32'(txd), 32'd1);
    endtask

    task automatic collect_bytes(input int count);
        logic [7:0] b;
        int n;
        for (n = 0; n < count; n++) begin
            read_frame(b);
            rx_bytes.push_back(b);
        end
    endtask

    // oldest sample of the group lands in bit 15
    function automatic logic [15:0] group_word(input int n);
        logic [15:0] w;
        int k;
        for (k = 0; k < 16; k++) begin
            w[15 - k] = sample_log[16 * n + k];
        end
        return w;
    endfunction

    function automatic logic window_matches(input int first);
        int i;
        for (i = 0; i < 256; i++) begin
            if ({rx_bytes[2 * i + 1], rx_bytes[2 * i]} != group_word(first + i)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_window(input int last_exp);
        int first;
        int c;
        int i;
        first = last_exp - 255;
        for (c = last_exp - 256; c <= last_exp - 254; c++) begin
            if (window_matches(c)) begin
                first = c; // trigger sync may shift the window by a word
            end
        end
        for (i = 0; i < 256; i++) begin
            check_equal("dump word", 32'({rx_bytes[2 * i + 1], rx_bytes[2 * i]}),
                        32'(group_word(first + i)));
        end
    endtask

    task automatic pulse_trig();
        @(posedge clk);
        trig <= 1'b1;
        repeat (4) @(posedge clk);
        trig <= 1'b0;
    endtask

    task automatic run_dump(input int trig_words, input int count_exp);
        logic [31:0] data;
        int n;
        rx_bytes.delete();
        fork
            collect_bytes(512);
            begin
                @(negedge clk);
                while (sample_log.size() < 16 * trig_words) begin
                    @(negedge clk);
                end
                pulse_trig();
                apb_read(`HD_REG_STAT, data);
                while (data[0] == 1'b0) begin
                    apb_read(`HD_REG_STAT, data); // until dumping
                end
                check_equal("stat.triggered", 32'(data[1]), 32'd1);
            end
        join
        apb_read(`HD_REG_STAT, data);
        while (data[0] == 1'b1) begin
            apb_read(`HD_REG_STAT, data);
        end
        check_equal("stat.dump_count", 32'(data[15:8]), 32'(count_exp));
        check_equal("stat.triggered", 32'(data[1]), 32'd0);
        for (n = 0; n < 20 * (BAUD + 1); n++) begin
            @(negedge clk);
            check_equal("txd after dump", 32'(txd), 32'd1); // no byte past 512
        end
        check_window(trig_words + POST_WORDS - 1);
    endtask

    task automatic check_registers();
        logic [31:0] data;
        apb_write(`HD_REG_SDIV, 32'h0000_a5c3);
        apb_write(`HD_REG_POST, 32'h0000_005a);
        apb_write(`HD_REG_BAUD, 32'h0000_1e0f);
        apb_read(`HD_REG_SDIV, data);
        check_equal("sample_div", data, 32'h0000_a5c3);
        apb_read(`HD_REG_POST, data);
        check_equal("post_words", data, 32'h0000_005a);
        apb_read(`HD_REG_BAUD, data);
        check_equal("baud_div", data, 32'h0000_1e0f);
        apb_read(8'h14, data);
        check_equal("unmapped read", data, 32'h0);
        apb_read(`HD_REG_STAT, data);
        check_equal("stat.dumping", 32'(data[0]), 32'd0);
        check_equal("stat.dump_count", 32'(data[15:8]), 32'd0);
    endtask

    task automatic capture_and_dump();
        apb_write(`HD_REG_SDIV, 32'(SDIV));
        apb_write(`HD_REG_POST, 32'(POST_WORDS));
        apb_write(`HD_REG_BAUD, 32'(BAUD));
        apb_write(`HD_REG_CTRL, 32'h1);
        en_model <= 1'b1; // sample model starts with the enable edge
        run_dump(TRIG_WORDS, 1);
    endtask

    task automatic rearm_and_dump();
        int target;
        @(negedge clk);
        target = sample_log.size() / 16 + TRIG_WORDS;
        run_dump(target, 2);
    endtask

    task automatic disabled_trigger();
        logic [31:0] data;
        int n;
        apb_write(`HD_REG_CTRL, 32'h0);
        en_model <= 1'b0;
        pulse_trig();
        for (n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            check_equal("txd while disabled", 32'(txd), 32'd1);
        end
        apb_read(`HD_REG_STAT, data);
        check_equal("stat.triggered", 32'(data[1]), 32'd0);
        check_equal("stat.dumping", 32'(data[0]), 32'd0);
    endtask

    initial begin
        rst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'h00;
        pwdata = 32'h0;
        trig = 1'b0;
        en_model = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        check_registers();
        capture_and_dump();
        rearm_and_dump();
        disabled_trigger();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
hdl/capture_pkg.sv
hdl/dump_regs.sv
hdl/bit_sampler.sv
hdl/capture_ram.sv
hdl/dump_sequencer.sv
hdl/uart_tx.sv
hdl/hex_dump_top.sv
test/hex_dump_assertions.sv
test/hex_dump_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module hex_dump_tb -o hex_dump_sim
	-./obj_dir/hex_dump_sim 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
